/* project.f */
+incdir+design
design/rec_geom_pkg.sv
design/rec_mem_pkg.sv
design/buf_ram_2p_64x512.sv
design/rec_addr_gen.sv
design/rec_wr_align.sv
design/rec_rd_align.sv
design/mem_pipo_2p.sv
tb/tb_mem_pipo_2p.sv

/* Bender.yml */
package:
  name: mem_pipo_2p

sources:
  - include_dirs:
      - design
    files:
      - design/rec_geom_pkg.sv
      - design/rec_mem_pkg.sv
      - design/buf_ram_2p_64x512.sv
      - design/rec_addr_gen.sv
      - design/rec_wr_align.sv
      - design/rec_rd_align.sv
      - design/mem_pipo_2p.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_mem_pipo_2p.sv

/* tb/tb_mem_pipo_2p.sv */
`include "rec_buf_defines.svh"

module tb_mem_pipo_2p;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ROW_W      = `BANK_NUM * `BANK_WIDTH;
	localparam int CLK_PERIOD = 8;
	// Reset, preload, four round trips, half words, regions, per-bank, mixed, hold
	localparam int TOTAL_OPS  = 8 + 512 + 4 * 33 + 33 + 113 + 41 + 2001 + 18;
	localparam int TIMEOUT_NS = TOTAL_OPS * CLK_PERIOD * 2;

	// Bank in each row slot with slot 0 in the top bits
	// One row each for 4x4/8x8, 16x16 and 32x32
	localparam logic [7:0] LANE_TAB [3][4] = '{
		'{8'b00_01_10_11, 8'b10_11_00_01, 8'b01_10_11_00, 8'b11_00_01_10},
		'{8'b00_10_01_11, 8'b10_00_11_01, 8'b01_11_10_00, 8'b11_01_00_10},
		'{8'b00_10_01_11, 8'b01_11_10_00, 8'b10_00_11_01, 8'b11_01_00_10}
	};

	logic                     clk, rst_n, a_wen, a_cbank, b_ren, b_cbank;
	rec_mem_pkg::region_e     a_bank [`BANK_NUM];
	rec_mem_pkg::region_e     b_bank;
	rec_geom_pkg::blk_size_e  a_size, b_size;
	logic [1:0]               a_sel, b_sel;
	logic [3:0]               a_x, a_y, b_x, b_y;
	logic [4:0]               a_idx, b_idx;
	logic [ROW_W-1:0]         a_wdata, b_rdata, pend_exp;
	logic                     pend_valid;    // A read result is due on b_rdata
	logic [`BANK_WIDTH-1:0]   shadow [`BANK_NUM][1 << `BANK_AW];
	string                    test_name;
	string                    size_name [4] = '{"rt_4x4", "rt_8x8", "rt_16x16", "rt_32x32"};
	int                       tests, checks, errors, test_errors;

	mem_pipo_2p dut0 (
		.clk        (clk),        .rst_n      (rst_n),      .a_wen_i    (a_wen),
		.a_bank_0_i (a_bank[0]),  .a_bank_1_i (a_bank[1]),
		.a_bank_2_i (a_bank[2]),  .a_bank_3_i (a_bank[3]),
		.a_cbank_i  (a_cbank),    .a_size_i   (a_size),     .a_sel_i    (a_sel),
		.a_4x4_x_i  (a_x),        .a_4x4_y_i  (a_y),        .a_idx_i    (a_idx),
		.a_wdata_i  (a_wdata),
		.b_ren_i    (b_ren),      .b_bank_i   (b_bank),     .b_cbank_i  (b_cbank),
		.b_size_i   (b_size),     .b_sel_i    (b_sel),
		.b_4x4_x_i  (b_x),        .b_4x4_y_i  (b_y),        .b_idx_i    (b_idx),
		.b_rdata_o  (b_rdata)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(TIMEOUT_NS);
		$display("Run timed out after %0d ns before all tests finished", TIMEOUT_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	function automatic logic [1:0] slot_bank(rec_geom_pkg::blk_size_e size, logic [3:0] x,
			logic [4:0] idx, int j);
		logic [1:0] sel;
		int row;
		case (size)
			rec_geom_pkg::size_16x16: row = 1;
			rec_geom_pkg::size_32x32: row = 2;
			default:                  row = 0;
		endcase
		sel = (row == 1) ? {x[2], idx[1]} : (row == 2) ? idx[1:0] : x[2:1];
		return LANE_TAB[row][sel][7-2*j -: 2];
	endfunction

	function automatic logic [`BANK_AW-1:0] bank_addr(int k, rec_mem_pkg::region_e region,
			rec_geom_pkg::blk_size_e size, logic [3:0] x, logic [3:0] y, logic [4:0] idx,
			logic cbank, logic [1:0] sel);
		logic [1:0] mid, lo, off;
		logic [2:0] hi;
		mid = (region == rec_mem_pkg::region_chroma) ? {cbank, sel[0]} : {y[3], x[3]};
		case (x[2:1])
			2'd1:    off = 2'd2;
			2'd2:    off = 2'd3;
			2'd3:    off = 2'd1;
			default: off = 2'd0;
		endcase
		case (size)
			rec_geom_pkg::size_4x4: begin
				hi = y[2:0];
				lo = 2'((k + off) % 4);
			end
			rec_geom_pkg::size_8x8: begin
				hi = {y[2:1], idx[2]};
				lo = 2'((k + off) % 4);
			end
			rec_geom_pkg::size_16x16: begin
				hi = {y[2], idx[3:2]};
				lo = {idx[1], x[2] ^ k[0]};
			end
			default: begin
				hi = idx[4:2];
				lo = idx[1:0];
			end
		endcase
		return {region, mid, hi, lo};
	endfunction

	function automatic logic [`BANK_AW-1:0] wr_addr(int k);
		return bank_addr(k, a_bank[k], a_size, a_x, a_y, a_idx, a_cbank, a_sel);
	endfunction

	function automatic logic [`BANK_AW-1:0] rd_addr(int k);
		return bank_addr(k, b_bank, b_size, b_x, b_y, b_idx, b_cbank, b_sel);
	endfunction

	function automatic logic [ROW_W-1:0] predict_read();
		logic [ROW_W-1:0] row;
		int b;
		for (int j = 0; j < `BANK_NUM; j++) begin
			b = slot_bank(b_size, b_x, b_idx, j);
			row[ROW_W-1-64*j -: 64] = shadow[b][rd_addr(b)];
		end
		return row;
	endfunction

	// Same bank and address on both ports gives undefined read data
	function automatic logic addr_clash();
		for (int k = 0; k < `BANK_NUM; k++) begin
			if (wr_addr(k) == rd_addr(k)) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic apply_write();
		int b;
		for (int j = 0; j < `BANK_NUM; j++) begin
			b = slot_bank(a_size, a_x, a_idx, j);
			if (a_size != rec_geom_pkg::size_4x4) begin
				shadow[b][wr_addr(b)] = a_wdata[ROW_W-1-64*j -: 64];
			end else if (a_x[0]) begin
				shadow[b][wr_addr(b)][31:0] = a_wdata[ROW_W-1-32*j -: 32];
			end else begin
				shadow[b][wr_addr(b)][63:32] = a_wdata[ROW_W-1-32*j -: 32];
			end
		end
	endtask

	// One clock from falling edge to falling edge
	// The previous read is checked first
	task automatic run_cycle(input logic wr, input logic rd);
		if (pend_valid) begin
			checks++;
			assert (b_rdata === pend_exp) else begin
				errors++;
				$display("ERR %s expected %h actual %h", test_name, pend_exp, b_rdata);
			end
		end
		a_wen = wr;
		b_ren = rd && !(wr && addr_clash());
		if (b_ren) begin
			pend_exp   = predict_read();
			pend_valid = 1'b1;
		end
		@(posedge clk);
		if (wr) begin
			apply_write();
		end
		@(negedge clk);
	endtask

	function automatic logic [ROW_W-1:0] rand_row();
		logic [ROW_W-1:0] row;
		for (int i = 0; i < ROW_W / 32; i++) begin
			row[32*i +: 32] = $urandom();
		end
		return row;
	endfunction

	task automatic rand_write(input int size, input logic spread);
		int r;
		r       = $urandom_range(3);
		a_size  = rec_geom_pkg::blk_size_e'(size);
		a_x     = 4'($urandom_range(15));
		a_y     = 4'($urandom_range(15));
		a_idx   = 5'($urandom_range(31));
		a_cbank = 1'($urandom_range(1));
		a_sel   = 2'($urandom_range(3));
		a_wdata = rand_row();
		for (int k = 0; k < `BANK_NUM; k++) begin
			a_bank[k] = rec_mem_pkg::region_e'(spread ? $urandom_range(3) : r);
		end
	endtask

	task automatic rand_read();
		b_bank  = rec_mem_pkg::region_e'($urandom_range(3));
		b_size  = rec_geom_pkg::blk_size_e'($urandom_range(3));
		b_x     = 4'($urandom_range(15));
		b_y     = 4'($urandom_range(15));
		b_idx   = 5'($urandom_range(31));
		b_cbank = 1'($urandom_range(1));
		b_sel   = 2'($urandom_range(3));
	endtask

	// Read back the geometry last written on port A
	task automatic read_back(input int region);
		b_bank  = rec_mem_pkg::region_e'(region);
		b_size  = a_size;
		b_x     = a_x;
		b_y     = a_y;
		b_idx   = a_idx;
		b_cbank = a_cbank;
		b_sel   = a_sel;
		run_cycle(1'b0, 1'b1);
	endtask

	// Regions 0 to 2 and then chroma with the four {cbank, sel[0]} pairs
	task automatic aim_region(input int c);
		for (int k = 0; k < `BANK_NUM; k++) begin
			a_bank[k] = rec_mem_pkg::region_e'(c < 3 ? c : 3);
		end
		if (c >= 3) begin
			{a_cbank, a_sel[0]} = 2'(c - 3);
		end
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		run_cycle(1'b0, 1'b0); // Lets the last read land
		tests++;
		$display("%-18s %s, %0d errors", test_name,
			(errors == test_errors) ? "ok" : "bad", errors - test_errors);
	endtask

	initial begin
		void'($urandom(94));
		rst_n      = 1'b0;
		a_wen      = 1'b0;
		a_bank     = '{default: rec_mem_pkg::region_pre};
		a_cbank    = 1'b0;
		a_size     = rec_geom_pkg::size_4x4;
		a_sel      = 2'd0;
		a_x        = 4'd0;
		a_y        = 4'd0;
		a_idx      = 5'd0;
		a_wdata    = '0;
		b_ren      = 1'b0;
		b_bank     = rec_mem_pkg::region_pre;
		b_cbank    = 1'b0;
		b_size     = rec_geom_pkg::size_4x4;
		b_sel      = 2'd0;
		b_x        = 4'd0;
		b_y        = 4'd0;
		b_idx      = 5'd0;
		pend_valid = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// 32x32 rows at every region, quadrant and index cover all words of every bank
		test_name = "preload";
		for (int w = 0; w < 512; w++) begin
			rand_write(3, 1'b0);
			aim_region(w[8:7]);
			{a_y[3], a_x[3]}     = w[6:5];
			{a_cbank, a_sel[0]} = w[6:5];
			a_idx                = w[4:0];
			run_cycle(1'b1, 1'b0);
		end

		for (int s = 0; s < 4; s++) begin
			begin_test(size_name[s]);
			repeat (16) begin
				rand_write(s, 1'b0);
				run_cycle(1'b1, 1'b0);
				read_back(a_bank[0]);
			end
			end_test();
		end

		begin_test("half_word_4x4");
		repeat (8) begin
			rand_write(0, 1'b0);
			a_x[0] = 1'b0;
			run_cycle(1'b1, 1'b0);
			a_x[0]  = 1'b1;    // Same bank word in the lower half
			a_wdata = rand_row();
			run_cycle(1'b1, 1'b0);
			read_back(a_bank[0]);
			a_x[0] = 1'b0;
			read_back(a_bank[0]);
		end
		end_test();

		begin_test("regions");
		repeat (8) begin
			rand_write($urandom_range(3), 1'b0);
			for (int c = 0; c < 7; c++) begin
				aim_region(c);
				a_wdata = rand_row();
				run_cycle(1'b1, 1'b0);
			end
			for (int c = 0; c < 7; c++) begin
				aim_region(c);
				read_back(a_bank[0]);
			end
		end
		end_test();

		begin_test("per_bank_regions");
		repeat (8) begin
			rand_write($urandom_range(3), 1'b0);
			for (int k = 0; k < `BANK_NUM; k++) begin
				a_bank[k] = rec_mem_pkg::region_e'(a_bank[k] ^ 2'(k)); // Four distinct regions
			end
			run_cycle(1'b1, 1'b0);
			for (int r = 0; r < 4; r++) begin
				read_back(r);
			end
		end
		end_test();

		begin_test("mixed_traffic");
		repeat (2000) begin
			rand_write($urandom_range(3), 1'b1);
			rand_read();
			run_cycle(1'b1, $urandom_range(3) != 0);
		end
		end_test();

		// Read geometry keeps moving while b_ren stays low
		begin_test("hold_idle");
		rand_read();
		run_cycle(1'b0, 1'b1);
		repeat (16) begin
			rand_write($urandom_range(3), 1'b1);
			rand_read();
			run_cycle(1'b1, 1'b0);
		end
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* design/mem_pipo_2p.sv */
`include "rec_buf_defines.svh"

module mem_pipo_2p (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              a_wen_i,
	input  rec_mem_pkg::region_e              a_bank_0_i,  // Region for bank 0
	input  rec_mem_pkg::region_e              a_bank_1_i,
	input  rec_mem_pkg::region_e              a_bank_2_i,
	input  rec_mem_pkg::region_e              a_bank_3_i,
	input  logic                              a_cbank_i,
	input  rec_geom_pkg::blk_size_e           a_size_i,
	input  logic [1:0]                        a_sel_i,
	input  rec_geom_pkg::coord_t              a_4x4_x_i,
	input  rec_geom_pkg::coord_t              a_4x4_y_i,
	input  rec_geom_pkg::row_idx_t            a_idx_i,
	input  logic [`BANK_NUM*`BANK_WIDTH-1:0]  a_wdata_i,
	input  logic                              b_ren_i,
	input  rec_mem_pkg::region_e              b_bank_i,
	input  logic                              b_cbank_i,
	input  rec_geom_pkg::blk_size_e           b_size_i,
	input  logic [1:0]                        b_sel_i,
	input  rec_geom_pkg::coord_t              b_4x4_x_i,
	input  rec_geom_pkg::coord_t              b_4x4_y_i,
	input  rec_geom_pkg::row_idx_t            b_idx_i,
	output logic [`BANK_NUM*`BANK_WIDTH-1:0]  b_rdata_o
);

	logic [`BANK_AW-1:0]     a_addr0, a_addr1, a_addr2, a_addr3;
	logic [`BANK_AW-1:0]     b_addr0, b_addr1, b_addr2, b_addr3;
	logic [1:0]              a_we0, a_we1, a_we2, a_we3;
	logic [`BANK_WIDTH-1:0]  a_data0, a_data1, a_data2, a_data3;
	logic [`BANK_WIDTH-1:0]  b_data0, b_data1, b_data2, b_data3;

	// Port A, one region per bank
	rec_addr_gen u_a_addr (
		.size_i    (a_size_i),   .x_i       (a_4x4_x_i),  .y_i     (a_4x4_y_i),
		.idx_i     (a_idx_i),
		.region0_i (a_bank_0_i), .region1_i (a_bank_1_i),
		.region2_i (a_bank_2_i), .region3_i (a_bank_3_i),
		.cbank_i   (a_cbank_i),  .sel_i     (a_sel_i),
		.addr0_o   (a_addr0),    .addr1_o   (a_addr1),
		.addr2_o   (a_addr2),    .addr3_o   (a_addr3)
	);

	rec_wr_align u_wr_align (
		.wen_i   (a_wen_i),  .size_i  (a_size_i), .x_i (a_4x4_x_i), .idx_i (a_idx_i),
		.wdata_i (a_wdata_i),
		.we0_o   (a_we0),    .we1_o   (a_we1),    .we2_o   (a_we2),   .we3_o   (a_we3),
		.data0_o (a_data0),  .data1_o (a_data1),  .data2_o (a_data2), .data3_o (a_data3)
	);

	// Port B reads a single region across all banks
	rec_addr_gen u_b_addr (
		.size_i    (b_size_i),  .x_i       (b_4x4_x_i), .y_i     (b_4x4_y_i),
		.idx_i     (b_idx_i),
		.region0_i (b_bank_i),  .region1_i (b_bank_i),
		.region2_i (b_bank_i),  .region3_i (b_bank_i),
		.cbank_i   (b_cbank_i), .sel_i     (b_sel_i),
		.addr0_o   (b_addr0),   .addr1_o   (b_addr1),
		.addr2_o   (b_addr2),   .addr3_o   (b_addr3)
	);

	rec_rd_align u_rd_align (
		.clk     (clk),      .rst_n   (rst_n),   .ren_i   (b_ren_i),
		.size_i  (b_size_i), .x_i     (b_4x4_x_i), .idx_i (b_idx_i),
		.data0_i (b_data0),  .data1_i (b_data1), .data2_i (b_data2), .data3_i (b_data3),
		.rdata_o (b_rdata_o)
	);

	buf_ram_2p_64x512 u_bank0 (
		.clk      (clk),
		.a_we_i   (a_we0),   .a_addr_i (a_addr0), .a_data_i (a_data0),
		.b_re_i   (b_ren_i), .b_addr_i (b_addr0), .b_data_o (b_data0)
	);

	buf_ram_2p_64x512 u_bank1 (
		.clk      (clk),
		.a_we_i   (a_we1),   .a_addr_i (a_addr1), .a_data_i (a_data1),
		.b_re_i   (b_ren_i), .b_addr_i (b_addr1), .b_data_o (b_data1)
	);

	buf_ram_2p_64x512 u_bank2 (
		.clk      (clk),
		.a_we_i   (a_we2),   .a_addr_i (a_addr2), .a_data_i (a_data2),
		.b_re_i   (b_ren_i), .b_addr_i (b_addr2), .b_data_o (b_data2)
	);

	buf_ram_2p_64x512 u_bank3 (
		.clk      (clk),
		.a_we_i   (a_we3),   .a_addr_i (a_addr3), .a_data_i (a_data3),
		.b_re_i   (b_ren_i), .b_addr_i (b_addr3), .b_data_o (b_data3)
	);

endmodule

/* design/rec_rd_align.sv */
`include "rec_buf_defines.svh"

module rec_rd_align (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              ren_i,
	input  rec_geom_pkg::blk_size_e           size_i,
	input  rec_geom_pkg::coord_t              x_i,
	input  rec_geom_pkg::row_idx_t            idx_i,
	input  logic [`BANK_WIDTH-1:0]            data0_i,
	input  logic [`BANK_WIDTH-1:0]            data1_i,
	input  logic [`BANK_WIDTH-1:0]            data2_i,
	input  logic [`BANK_WIDTH-1:0]            data3_i,
	output logic [`BANK_NUM*`BANK_WIDTH-1:0]  rdata_o
);

	localparam int ROW_W = `BANK_NUM * `BANK_WIDTH;

	rec_geom_pkg::blk_size_e  size_r;
	logic [1:0]               x_r;    // x[2:1] of the read in flight
	logic [1:0]               idx_r;  // idx[1:0] of the read in flight
	logic [2*`BANK_NUM-1:0]   order;
	logic [`BANK_WIDTH-1:0]   bank_data [`BANK_NUM];

	// Geometry loads at the same edge as the bank read registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			size_r <= rec_geom_pkg::size_4x4;
			x_r    <= 2'b00;
			idx_r  <= 2'b00;
		end else if (ren_i) begin
			size_r <= size_i;
			x_r    <= x_i[2:1];
			idx_r  <= idx_i[1:0];
		end
	end

	assign bank_data[0] = data0_i;
	assign bank_data[1] = data1_i;
	assign bank_data[2] = data2_i;
	assign bank_data[3] = data3_i;

	assign order = rec_geom_pkg::lane_order(size_r, x_r, idx_r);

	// Put each bank word back in its slot
	always_comb begin
		for (int j = 0; j < `BANK_NUM; j++) begin
			rdata_o[ROW_W-1-j*`BANK_WIDTH -: `BANK_WIDTH] =
				bank_data[order[2*`BANK_NUM-1-2*j -: 2]];
		end
	end

endmodule

/* design/rec_wr_align.sv */
`include "rec_buf_defines.svh"

module rec_wr_align (
	input  logic                               wen_i,
	input  rec_geom_pkg::blk_size_e            size_i,
	input  rec_geom_pkg::coord_t               x_i,
	input  rec_geom_pkg::row_idx_t             idx_i,
	input  logic [`BANK_NUM*`BANK_WIDTH-1:0]   wdata_i,
	output logic [1:0]                         we0_o,
	output logic [1:0]                         we1_o,
	output logic [1:0]                         we2_o,
	output logic [1:0]                         we3_o,
	output logic [`BANK_WIDTH-1:0]             data0_o,
	output logic [`BANK_WIDTH-1:0]             data1_o,
	output logic [`BANK_WIDTH-1:0]             data2_o,
	output logic [`BANK_WIDTH-1:0]             data3_o
);

	localparam int ROW_W  = `BANK_NUM * `BANK_WIDTH;
	localparam int HALF_W = `BANK_WIDTH / 2;

	logic [2*`BANK_NUM-1:0]  order;
	logic [1:0]              we;
	logic [`BANK_WIDTH-1:0]  slot_data [`BANK_NUM];
	logic [`BANK_WIDTH-1:0]  bank_data [`BANK_NUM];

	assign order = rec_geom_pkg::lane_order(size_i, x_i[2:1], idx_i[1:0]);

	// A 4x4 row goes to both halves, the enable picks the one that is written
	always_comb begin
		for (int j = 0; j < `BANK_NUM; j++) begin
			if (size_i == rec_geom_pkg::size_4x4) begin
				slot_data[j] = {2{wdata_i[ROW_W-1-j*HALF_W -: HALF_W]}};
			end else begin
				slot_data[j] = wdata_i[ROW_W-1-j*`BANK_WIDTH -: `BANK_WIDTH];
			end
		end
	end

	always_comb begin
		bank_data = '{default: '0};
		for (int j = 0; j < `BANK_NUM; j++) begin
			bank_data[order[2*`BANK_NUM-1-2*j -: 2]] = slot_data[j];
		end
	end

	always_comb begin
		if (!wen_i) begin
			we = 2'b00;
		end else if (size_i == rec_geom_pkg::size_4x4) begin
			we = x_i[0] ? 2'b01 : 2'b10; // Odd x takes the lower half
		end else begin
			we = 2'b11;
		end
	end

	assign we0_o = we;
	assign we1_o = we;
	assign we2_o = we;
	assign we3_o = we;

	assign data0_o = bank_data[0];
	assign data1_o = bank_data[1];
	assign data2_o = bank_data[2];
	assign data3_o = bank_data[3];

endmodule

/* design/rec_addr_gen.sv */
`include "rec_buf_defines.svh"

module rec_addr_gen (
	input  rec_geom_pkg::blk_size_e size_i,
	input  rec_geom_pkg::coord_t    x_i,        // Top left 4x4 block x
	input  rec_geom_pkg::coord_t    y_i,        // Top left 4x4 block y
	input  rec_geom_pkg::row_idx_t  idx_i,      // Row within the block
	input  rec_mem_pkg::region_e    region0_i,
	input  rec_mem_pkg::region_e    region1_i,
	input  rec_mem_pkg::region_e    region2_i,
	input  rec_mem_pkg::region_e    region3_i,
	input  logic                    cbank_i,
	input  logic [1:0]              sel_i,
	output logic [`BANK_AW-1:0]     addr0_o,
	output logic [`BANK_AW-1:0]     addr1_o,
	output logic [`BANK_AW-1:0]     addr2_o,
	output logic [`BANK_AW-1:0]     addr3_o
);

	rec_mem_pkg::region_e    region [`BANK_NUM];
	rec_mem_pkg::bank_addr_t addr [`BANK_NUM];
	logic [2:0]              row_sel;  // Low address bits 4:2, same for every bank
	logic [1:0]              col_off;  // Column offset for 4x4 and 8x8

	assign region[0] = region0_i;
	assign region[1] = region1_i;
	assign region[2] = region2_i;
	assign region[3] = region3_i;

	always_comb begin
		case (size_i)
			rec_geom_pkg::size_4x4:   row_sel = y_i[2:0];
			rec_geom_pkg::size_8x8:   row_sel = {y_i[2:1], idx_i[2]};
			rec_geom_pkg::size_16x16: row_sel = {y_i[2], idx_i[3:2]};
			default:                  row_sel = idx_i[4:2];
		endcase
	end

	always_comb begin
		case (x_i[2:1])
			2'd0:    col_off = 2'd0;
			2'd1:    col_off = 2'd2;
			2'd2:    col_off = 2'd3;
			default: col_off = 2'd1;
		endcase
	end

	always_comb begin
		for (int k = 0; k < `BANK_NUM; k++) begin
			addr[k].region = region[k];
			// Chroma reuses the quadrant bits for its own sub-banks
			if (region[k] == rec_mem_pkg::region_chroma) begin
				addr[k].mid = {cbank_i, sel_i[0]};
			end else begin
				addr[k].mid = {y_i[3], x_i[3]};
			end
			case (size_i)
				rec_geom_pkg::size_16x16: addr[k].low[1:0] = {idx_i[1], x_i[2] ^ k[0]};
				rec_geom_pkg::size_32x32: addr[k].low[1:0] = idx_i[1:0];
				default:                  addr[k].low[1:0] = 2'(k) + col_off; // Wraps mod 4
			endcase
			addr[k].low[4:2] = row_sel;
		end
	end

	assign addr0_o = addr[0];
	assign addr1_o = addr[1];
	assign addr2_o = addr[2];
	assign addr3_o = addr[3];

endmodule

/* design/buf_ram_2p_64x512.sv */
`include "rec_buf_defines.svh"

module buf_ram_2p_64x512 (
	input  logic                    clk,
	input  logic [1:0]              a_we_i,   // Bit 1 upper half, bit 0 lower half
	input  logic [`BANK_AW-1:0]     a_addr_i,
	input  logic [`BANK_WIDTH-1:0]  a_data_i,
	input  logic                    b_re_i,
	input  logic [`BANK_AW-1:0]     b_addr_i,
	output logic [`BANK_WIDTH-1:0]  b_data_o
);

	localparam int HALF_W = `BANK_WIDTH / 2;
	localparam int DEPTH  = 1 << `BANK_AW;

	logic [`BANK_WIDTH-1:0] mem [DEPTH];

	// Write port, each half has its own enable
	always_ff @(posedge clk) begin
		if (a_we_i[1]) begin
			mem[a_addr_i][`BANK_WIDTH-1:HALF_W] <= a_data_i[`BANK_WIDTH-1:HALF_W];
		end
		if (a_we_i[0]) begin
			mem[a_addr_i][HALF_W-1:0] <= a_data_i[HALF_W-1:0];
		end
	end

	// Read port, output register holds while idle
	always_ff @(posedge clk) begin
		if (b_re_i) begin
			b_data_o <= mem[b_addr_i];
		end
	end

endmodule

/* design/rec_mem_pkg.sv */
package rec_mem_pkg;

	// Buffer regions, one per encoder stage plus chroma
	typedef enum logic [1:0] {
		region_pre    = 2'd0, // Luma prediction
		region_min    = 2'd1, // Luma after mode decision
		region_ec     = 2'd2, // Luma for entropy coding
		region_chroma = 2'd3
	} region_e;

	localparam int MID_W = 2;
	localparam int LOW_W = 5;

	// Bank address, region in the top bits
	typedef struct packed {
		region_e          region;
		logic [MID_W-1:0] mid;  // {y[3], x[3]} or {cbank, sel[0]} for chroma
		logic [LOW_W-1:0] low;  // Row and column within the 32x32 quadrant
	} bank_addr_t;

endpackage

/* design/rec_geom_pkg.sv */
package rec_geom_pkg;

	typedef enum logic [1:0] {
		size_4x4   = 2'd0,
		size_8x8   = 2'd1,
		size_16x16 = 2'd2,
		size_32x32 = 2'd3
	} blk_size_e;

	localparam int COORD_W = 4; // Position in 4x4 units inside a 64x64 area
	localparam int IDX_W   = 5; // Row index inside a block

	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [IDX_W-1:0]   row_idx_t;

	// Bank number in each 64-bit slot of a row, slot 0 in the top two bits.
	// Write and read sides share this table
	function automatic logic [7:0] lane_order(blk_size_e size, logic [1:0] x21,
			logic [1:0] idx10);
		logic [1:0] sel;
		case (size)
			size_16x16: sel = {x21[1], idx10[1]};
			size_32x32: sel = idx10;
			default:    sel = x21;
		endcase
		case (size)
			size_16x16: begin
				case (sel)
					2'd0:    lane_order = 8'b00_10_01_11;
					2'd1:    lane_order = 8'b10_00_11_01;
					2'd2:    lane_order = 8'b01_11_10_00;
					default: lane_order = 8'b11_01_00_10;
				endcase
			end
			size_32x32: begin
				case (sel)
					2'd0:    lane_order = 8'b00_10_01_11;
					2'd1:    lane_order = 8'b01_11_10_00;
					2'd2:    lane_order = 8'b10_00_11_01;
					default: lane_order = 8'b11_01_00_10;
				endcase
			end
			default: begin // 4x4 and 8x8 rotate by x
				case (sel)
					2'd0:    lane_order = 8'b00_01_10_11;
					2'd1:    lane_order = 8'b10_11_00_01;
					2'd2:    lane_order = 8'b01_10_11_00;
					default: lane_order = 8'b11_00_01_10;
				endcase
			end
		endcase
	endfunction

endpackage

/* design/rec_buf_defines.svh */
`ifndef REC_BUF_DEFINES_SVH
`define REC_BUF_DEFINES_SVH

// Bits per pixel
`define PIXEL_WIDTH 8

// One bank word carries 8 pixels
`define BANK_WIDTH (`PIXEL_WIDTH * 8)

// 512 words per bank
`define BANK_AW 9

// Four banks side by side give one 32-pixel row
`define BANK_NUM 4

`endif
